// File: list.f
+incdir+hw
hw/cpu_pkg.sv
hw/sram.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/cpu.sv
bench/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compiles the core and its testbench with Verilator, runs it, and decides pass or fail from the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
   --top-module cpu_tb -Mdir "$BUILD_DIR" -f list.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vcpu_tb" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

grep -q "^Result: PASSED$" "$SIM_LOG"
exit $?

// File: bench/cpu_tb.sv
// one straight-line program; memories are loaded and read back only while enable is low
`default_nettype none
`include "cpu_config.svh"

module cpu_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 5;
   localparam int RUN_CYCLES   = 200;
   localparam int IMEM_FILL    = 256;
   localparam int OPERANDS     = 8;
   localparam int RESULT_BASE  = 64;
   localparam int RESULT_LAST  = 79;

   logic                  clk;
   logic                  rst_n;
   logic                  enable;
   cpu_pkg::ext_req_t     imem_ext;
   cpu_pkg::ext_req_t     dmem_ext;
   cpu_pkg::word_t        imem_ext_rdata;
   cpu_pkg::word_t        dmem_ext_rdata;

   logic                  chk_en;
   logic                  imem_chk_en;
   cpu_pkg::word_t        chk_exp;
   int                    chk_addr;
   int                    error_count;
   int                    check_count;
   logic [31:0]           rng_state;
   cpu_pkg::word_t        prog [$];
   cpu_pkg::word_t        model_regs [`CPU_REG_COUNT];
   cpu_pkg::word_t        model_mem [2 ** `CPU_DMEM_ADDR_W];

   cpu i_cpu (
      .clk            (clk),
      .rst_n          (rst_n),
      .enable         (enable),
      .imem_ext       (imem_ext),
      .imem_ext_rdata (imem_ext_rdata),
      .dmem_ext       (dmem_ext),
      .dmem_ext_rdata (dmem_ext_rdata)
   );

   always #2 clk = ~clk;

   // read data must show up at the edge after the one that took ren
   a_readback: assert property (@(posedge clk) disable iff (!rst_n)
      chk_en |=> (dmem_ext_rdata == chk_exp))
   else begin
      error_count++;
      $display("Error at %0t ns: dmem[%0d] reads %h, expected %h",
               $time, chk_addr, dmem_ext_rdata, chk_exp);
   end

   a_imem_readback: assert property (@(posedge clk) disable iff (!rst_n)
      imem_chk_en |=> (imem_ext_rdata == chk_exp))
   else begin
      error_count++;
      $display("Error at %0t ns: imem[%0d] reads %h, expected %h",
               $time, chk_addr, imem_ext_rdata, chk_exp);
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic cpu_pkg::word_t rtype_word(input logic [5:0] funct, input int rd,
                                                 input int rs, input int rt);
      return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
   endfunction

   function automatic cpu_pkg::word_t itype_word(input logic [5:0] op, input int rt,
                                                 input int rs, input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   // sequential ISA model, one instruction at a time
   task automatic model_step(input cpu_pkg::word_t w);
      logic [5:0]     op;
      logic [5:0]     fn;
      logic [4:0]     dst;
      cpu_pkg::word_t a;
      cpu_pkg::word_t b;
      cpu_pkg::word_t imm;
      cpu_pkg::word_t res;
      cpu_pkg::word_t maddr;
      logic           wr;
      op    = w[31:26];
      fn    = w[5:0];
      a     = model_regs[w[25:21]];
      b     = model_regs[w[20:16]];
      imm   = {{16{w[15]}}, w[15:0]};
      maddr = a + imm;
      dst   = w[20:16];
      res   = '0;
      wr    = 1'b0;
      case (op)
         cpu_pkg::OP_RTYPE: begin
            dst = w[15:11];
            wr  = 1'b1;
            case (fn)
               cpu_pkg::FN_ADD: res = a + b;
               cpu_pkg::FN_SUB: res = a - b;
               cpu_pkg::FN_AND: res = a & b;
               cpu_pkg::FN_OR:  res = a | b;
               cpu_pkg::FN_SLT: res = {31'd0, $signed(a) < $signed(b)};
               default:         wr = 1'b0;
            endcase
         end
         cpu_pkg::OP_ADDI: begin
            res = a + imm;
            wr  = 1'b1;
         end
         cpu_pkg::OP_LW: begin
            res = model_mem[maddr[`CPU_DMEM_ADDR_W-1:0]];
            wr  = 1'b1;
         end
         cpu_pkg::OP_SW: model_mem[maddr[`CPU_DMEM_ADDR_W-1:0]] = b;
         default: ;
      endcase
      if (wr && dst != 5'd0) begin
         model_regs[dst] = res;
      end
   endtask

   task automatic build_program();
      prog.delete();
      for (int r = 1; r <= 4; r++) begin
         prog.push_back(itype_word(cpu_pkg::OP_LW, r, 0, r - 1));
      end
      // each op needs the one right before it
      prog.push_back(rtype_word(cpu_pkg::FN_ADD, 5, 1, 2));
      prog.push_back(rtype_word(cpu_pkg::FN_SUB, 6, 5, 3));
      prog.push_back(rtype_word(cpu_pkg::FN_AND, 7, 6, 4));
      prog.push_back(rtype_word(cpu_pkg::FN_OR, 8, 7, 1));
      prog.push_back(rtype_word(cpu_pkg::FN_SLT, 9, 8, 2));
      for (int r = 5; r <= 9; r++) begin
         prog.push_back(itype_word(cpu_pkg::OP_SW, r, 0, RESULT_BASE + r - 5));
      end
      // producers two and three slots back
      prog.push_back(rtype_word(cpu_pkg::FN_ADD, 10, 1, 3));
      prog.push_back(rtype_word(cpu_pkg::FN_OR, 11, 2, 4));
      prog.push_back(rtype_word(cpu_pkg::FN_SUB, 12, 10, 2));
      prog.push_back(rtype_word(cpu_pkg::FN_AND, 13, 11, 10));
      prog.push_back(rtype_word(cpu_pkg::FN_ADD, 14, 12, 1));
      for (int r = 10; r <= 14; r++) begin
         prog.push_back(itype_word(cpu_pkg::OP_SW, r, 0, RESULT_BASE + r - 5));
      end
      // load-use pairs, one feeding an add and one feeding a store
      prog.push_back(itype_word(cpu_pkg::OP_LW, 15, 0, 4));
      prog.push_back(rtype_word(cpu_pkg::FN_ADD, 16, 15, 1));
      prog.push_back(itype_word(cpu_pkg::OP_SW, 16, 0, RESULT_BASE + 10));
      prog.push_back(itype_word(cpu_pkg::OP_LW, 17, 0, 5));
      prog.push_back(itype_word(cpu_pkg::OP_SW, 17, 0, RESULT_BASE + 11));
      prog.push_back(itype_word(cpu_pkg::OP_ADDI, 0, 0, 123));
      prog.push_back(itype_word(cpu_pkg::OP_SW, 0, 0, RESULT_BASE + 12));
      prog.push_back(itype_word(cpu_pkg::OP_ADDI, 18, 1, -5));
      prog.push_back(itype_word(cpu_pkg::OP_SW, 18, 0, RESULT_BASE + 13));
      // function code 0 is not an add, so r19 keeps 7
      prog.push_back(itype_word(cpu_pkg::OP_ADDI, 19, 0, 7));
      prog.push_back(rtype_word(6'd0, 19, 1, 2));
      prog.push_back(itype_word(cpu_pkg::OP_SW, 19, 0, RESULT_BASE + 14));
   endtask

   task automatic wait_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
      end
   endtask

   task automatic write_imem(input int addr, input cpu_pkg::word_t data);
      imem_ext.addr  = cpu_pkg::word_t'(addr);
      imem_ext.wdata = data;
      imem_ext.wen   = 1'b1;
      @(negedge clk);
      imem_ext.wen = 1'b0;
   endtask

   task automatic write_dmem(input int addr, input cpu_pkg::word_t data);
      dmem_ext.addr  = cpu_pkg::word_t'(addr);
      dmem_ext.wdata = data;
      dmem_ext.wen   = 1'b1;
      @(negedge clk);
      dmem_ext.wen = 1'b0;
   endtask

   // one read, then an idle cycle while the assertion looks at the data
   task automatic read_check(input int addr, input cpu_pkg::word_t expected);
      dmem_ext.addr = cpu_pkg::word_t'(addr);
      dmem_ext.ren  = 1'b1;
      chk_en        = 1'b1;
      chk_exp       = expected;
      chk_addr      = addr;
      check_count++;
      @(negedge clk);
      dmem_ext.ren = 1'b0;
      chk_en       = 1'b0;
      @(negedge clk);
   endtask

   task automatic read_imem_check(input int addr, input cpu_pkg::word_t expected);
      imem_ext.addr = cpu_pkg::word_t'(addr);
      imem_ext.ren  = 1'b1;
      imem_chk_en   = 1'b1;
      chk_exp       = expected;
      chk_addr      = addr;
      check_count++;
      @(negedge clk);
      imem_ext.ren = 1'b0;
      imem_chk_en  = 1'b0;
      @(negedge clk);
   endtask

   task automatic check_memory();
      for (int a = 0; a < OPERANDS; a++) begin
         read_check(a, model_mem[a]);
      end
      for (int a = RESULT_BASE; a <= RESULT_LAST; a++) begin
         read_check(a, model_mem[a]);
      end
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      enable      = 1'b0;
      imem_ext    = '0;
      dmem_ext    = '0;
      chk_en      = 1'b0;
      imem_chk_en = 1'b0;
      chk_exp     = '0;
      chk_addr    = 0;
      error_count = 0;
      check_count = 0;
      rng_state   = 32'd92711;
      foreach (model_regs[i]) model_regs[i] = '0;
      foreach (model_mem[i]) model_mem[i] = '0;

      wait_cycles(RESET_CYCLES);
      rst_n = 1'b1;

      for (int i = 0; i < OPERANDS; i++) begin
         model_mem[i] = next_random();
         write_dmem(i, model_mem[i]);
      end
      build_program();
      for (int i = 0; i < IMEM_FILL; i++) begin
         write_imem(i, (i < prog.size()) ? prog[i] : '0);
      end

      // program and the nop fill behind it come back through the instruction port
      foreach (prog[i]) read_imem_check(i, prog[i]);
      read_imem_check(prog.size(), '0);

      // frozen core with a program loaded must leave data memory as preloaded
      wait_cycles(20);
      check_memory();

      foreach (prog[i]) model_step(prog[i]);
      enable = 1'b1;
      wait_cycles(RUN_CYCLES);
      enable = 1'b0;
      wait_cycles(2);
      check_memory();
      wait_cycles(2);

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/cpu.sv
// five-stage core without branches; use the external memory ports only while enable is low
`default_nettype none
`include "cpu_config.svh"

module cpu (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    enable,
   input  wire cpu_pkg::ext_req_t imem_ext,
   output cpu_pkg::word_t         imem_ext_rdata,
   input  wire cpu_pkg::ext_req_t dmem_ext,
   output cpu_pkg::word_t         dmem_ext_rdata
);

   typedef struct packed {
      logic               reg_write;
      logic               mem_to_reg;
      cpu_pkg::reg_addr_t dest;
      cpu_pkg::word_t     alu_result;
   } mem_wb_t;

   cpu_pkg::word_t     instr;
   logic               stall;
   cpu_pkg::id_ex_t    id_ex;
   cpu_pkg::ex_mem_t   ex_mem;
   mem_wb_t            mem_wb;
   cpu_pkg::rf_write_t wb;
   cpu_pkg::word_t     load_data;
   logic               dmem_wen;
   logic               dmem_ren;

   fetch_stage i_fetch_stage (
      .clk            (clk),
      .rst_n          (rst_n),
      .run            (enable),
      .stall          (stall),
      .imem_ext       (imem_ext),
      .imem_ext_rdata (imem_ext_rdata),
      .instr          (instr)
   );

   decode_stage i_decode_stage (
      .clk   (clk),
      .rst_n (rst_n),
      .run   (enable),
      .instr (instr),
      .wb    (wb),
      .id_ex (id_ex),
      .stall (stall)
   );

   execute_stage i_execute_stage (
      .clk    (clk),
      .rst_n  (rst_n),
      .run    (enable),
      .id_ex  (id_ex),
      .wb     (wb),
      .ex_mem (ex_mem)
   );

   assign dmem_wen = enable && ex_mem.mem_write;
   assign dmem_ren = enable && ex_mem.mem_read;

   // load data arrives with the memory/writeback register
   sram #(
      .ADDR_W (`CPU_DMEM_ADDR_W),
      .DATA_W (`CPU_XLEN)
   ) i_dmem (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (ex_mem.alu_result),
      .wen       (dmem_wen),
      .ren       (dmem_ren),
      .wdata     (ex_mem.store_data),
      .rdata     (load_data),
      .ext       (dmem_ext),
      .ext_rdata (dmem_ext_rdata)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_wb.reg_write  <= 1'b0;
         mem_wb.mem_to_reg <= 1'b0;
      end else if (enable) begin
         mem_wb.reg_write  <= ex_mem.reg_write;
         mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
         mem_wb.dest       <= ex_mem.dest;
         mem_wb.alu_result <= ex_mem.alu_result;
      end
   end

   always_comb begin
      wb.we   = mem_wb.reg_write;
      wb.addr = mem_wb.dest;
      wb.data = mem_wb.mem_to_reg ? load_data : mem_wb.alu_result;
   end

   // frozen core keeps the stage registers that feed data memory
   a_freeze: assert property (@(posedge clk) disable iff (!rst_n)
      !enable |=> ($stable(ex_mem) && $stable(id_ex)));

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
// forwards from execute/memory (never a load) then writeback; slt is a signed compare
`default_nettype none

module execute_stage (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     run,
   input  wire cpu_pkg::id_ex_t    id_ex,
   input  wire cpu_pkg::rf_write_t wb,
   output cpu_pkg::ex_mem_t        ex_mem
);

   cpu_pkg::word_t op_a;
   cpu_pkg::word_t rt_fwd;
   cpu_pkg::word_t op_b;
   cpu_pkg::word_t result;

   // newest producer wins, r0 never forwards
   function automatic cpu_pkg::word_t forward(
      input cpu_pkg::reg_addr_t idx,
      input cpu_pkg::word_t     rf_val,
      input cpu_pkg::ex_mem_t   em,
      input cpu_pkg::rf_write_t w
   );
      if (idx != '0 && em.reg_write && !em.mem_read && em.dest == idx) begin
         return em.alu_result;
      end
      if (idx != '0 && w.we && w.addr == idx) begin
         return w.data;
      end
      return rf_val;
   endfunction

   always_comb begin
      op_a   = forward(id_ex.rs, id_ex.rs_val, ex_mem, wb);
      rt_fwd = forward(id_ex.rt, id_ex.rt_val, ex_mem, wb);
      op_b   = id_ex.ctrl.use_imm ? id_ex.imm : rt_fwd;
   end

   always_comb begin
      case (id_ex.ctrl.alu_op)
         cpu_pkg::ALU_ADD: result = op_a + op_b;
         cpu_pkg::ALU_SUB: result = op_a - op_b;
         cpu_pkg::ALU_AND: result = op_a & op_b;
         cpu_pkg::ALU_OR:  result = op_a | op_b;
         cpu_pkg::ALU_SLT: result = cpu_pkg::word_t'($signed(op_a) < $signed(op_b));
         default:          result = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_mem.mem_read   <= 1'b0;
         ex_mem.mem_write  <= 1'b0;
         ex_mem.mem_to_reg <= 1'b0;
         ex_mem.reg_write  <= 1'b0;
      end else if (run) begin
         ex_mem.mem_read   <= id_ex.ctrl.mem_read;
         ex_mem.mem_write  <= id_ex.ctrl.mem_write;
         ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
         ex_mem.reg_write  <= id_ex.ctrl.reg_write;
         ex_mem.dest       <= id_ex.dest;
         ex_mem.alu_result <= result;
         // store data is forwarded like any rt operand
         ex_mem.store_data <= rt_fwd;
      end
   end

   // decode never produces an access that both loads and stores
   a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(ex_mem.mem_read && ex_mem.mem_write));

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
// decodes add, sub, and, or, slt, addi, lw and sw; any other word becomes a nop
`default_nettype none
`include "cpu_config.svh"

module decode_stage (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     run,
   input  wire cpu_pkg::word_t     instr,
   input  wire cpu_pkg::rf_write_t wb,
   output cpu_pkg::id_ex_t         id_ex,
   output logic                    stall
);

   cpu_pkg::opcode_e   opcode;
   cpu_pkg::funct_e    funct;
   cpu_pkg::reg_addr_t rs;
   cpu_pkg::reg_addr_t rt;
   cpu_pkg::reg_addr_t rd;
   cpu_pkg::reg_addr_t dest;
   cpu_pkg::word_t     imm;
   cpu_pkg::word_t     rs_val;
   cpu_pkg::word_t     rt_val;
   cpu_pkg::ctrl_t     ctrl;

   cpu_pkg::word_t regs [`CPU_REG_COUNT];

   assign opcode = cpu_pkg::opcode_e'(instr[31:26]);
   assign funct  = cpu_pkg::funct_e'(instr[5:0]);
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign imm    = cpu_pkg::word_t'($signed(instr[15:0]));
   assign dest   = (opcode == cpu_pkg::OP_RTYPE) ? rd : rt;

   always_comb begin
      ctrl = '0;
      case (opcode)
         cpu_pkg::OP_RTYPE: begin
            ctrl.reg_write = 1'b1;
            case (funct)
               cpu_pkg::FN_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
               cpu_pkg::FN_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
               cpu_pkg::FN_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::FN_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
               cpu_pkg::FN_SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
               // unknown function codes write nothing
               default: ctrl.reg_write = 1'b0;
            endcase
         end
         cpu_pkg::OP_ADDI: begin
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         cpu_pkg::OP_LW: begin
            ctrl.use_imm    = 1'b1;
            ctrl.mem_read   = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.reg_write  = 1'b1;
         end
         cpu_pkg::OP_SW: begin
            ctrl.use_imm   = 1'b1;
            ctrl.mem_write = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (run && wb.we && wb.addr != '0) begin
         regs[wb.addr] <= wb.data;
      end
   end

   // write-first, so a same-cycle writeback is seen here
   function automatic cpu_pkg::word_t rf_read(cpu_pkg::reg_addr_t idx);
      if (idx == '0) begin
         return '0;
      end
      if (wb.we && wb.addr == idx) begin
         return wb.data;
      end
      return regs[idx];
   endfunction

   always_comb begin
      rs_val = rf_read(rs);
      rt_val = rf_read(rt);
   end

   // load in execute whose result is needed right now
   assign stall = id_ex.ctrl.mem_read && (id_ex.dest == rs || id_ex.dest == rt);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         id_ex.ctrl <= '0;
      end else if (run) begin
         if (stall) begin
            id_ex.ctrl <= '0;
         end else begin
            id_ex.ctrl <= ctrl;
         end
         id_ex.rs     <= rs;
         id_ex.rs_val <= rs_val;
         id_ex.rt     <= rt;
         id_ex.rt_val <= rt_val;
         id_ex.imm    <= imm;
         id_ex.dest   <= dest;
      end
   end

   // a stalled instruction comes back unchanged on the next cycle
   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (stall && run) |=> $stable(instr));

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
// PC counts words from 0; programs longer than the instruction memory are not supported
`default_nettype none
`include "cpu_config.svh"

module fetch_stage (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    run,
   input  wire                    stall,
   input  wire cpu_pkg::ext_req_t imem_ext,
   output cpu_pkg::word_t         imem_ext_rdata,
   output cpu_pkg::word_t         instr
);

   cpu_pkg::word_t pc;
   logic           advance;

   // a stall or a frozen core keeps both the PC and the fetched word
   assign advance = run && !stall;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (advance) begin
         pc <= pc + 1'b1;
      end
   end

   // registered read output is the fetch/decode register
   sram #(
      .ADDR_W (`CPU_IMEM_ADDR_W),
      .DATA_W (`CPU_XLEN)
   ) i_imem (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (pc),
      .wen       (1'b0),
      .ren       (advance),
      .wdata     ('0),
      .rdata     (instr),
      .ext       (imem_ext),
      .ext_rdata (imem_ext_rdata)
   );

endmodule

`default_nettype wire

// File: hw/sram.sv
// two-port RAM with registered reads that hold while ren is low; an external write wins a clash
`default_nettype none

module sram #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 32
) (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire cpu_pkg::word_t    addr,
   input  wire                    wen,
   input  wire                    ren,
   input  wire cpu_pkg::word_t    wdata,
   output cpu_pkg::word_t         rdata,
   input  wire cpu_pkg::ext_req_t ext,
   output cpu_pkg::word_t         ext_rdata
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   // single write port, external side has priority
   always_ff @(posedge clk) begin
      if (ext.wen) begin
         mem[ext.addr[ADDR_W-1:0]] <= ext.wdata;
      end else if (wen) begin
         mem[addr[ADDR_W-1:0]] <= wdata;
      end
   end

   // read data comes back at the next edge and holds after that
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rdata     <= '0;
         ext_rdata <= '0;
      end else begin
         if (ren) begin
            rdata <= mem[addr[ADDR_W-1:0]];
         end
         if (ext.ren) begin
            ext_rdata <= mem[ext.addr[ADDR_W-1:0]];
         end
      end
   end

   // addresses from the pipeline and from outside must stay inside the array
   a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
      ((wen || ren) |-> (addr < DEPTH)) and ((ext.wen || ext.ren) |-> (ext.addr < DEPTH)));

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
// shared core types; encodings follow the MIPS opcode and function fields
`default_nettype none
`include "cpu_config.svh"

package cpu_pkg;

   typedef logic [`CPU_XLEN-1:0] word_t;
   typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;

   // primary opcode, bits 31:26
   typedef enum logic [5:0] {
      OP_RTYPE = 6'd0,
      OP_ADDI  = 6'd8,
      OP_LW    = 6'd35,
      OP_SW    = 6'd43
   } opcode_e;

   // R-type function code, bits 5:0
   typedef enum logic [5:0] {
      FN_ADD = 6'd32,
      FN_SUB = 6'd34,
      FN_AND = 6'd36,
      FN_OR  = 6'd37,
      FN_SLT = 6'd42
   } funct_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_e;

   // all zero is a bubble
   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    mem_read;
      logic    mem_write;
      logic    mem_to_reg;
      logic    reg_write;
   } ctrl_t;

   typedef struct packed {
      ctrl_t     ctrl;
      reg_addr_t rs;
      word_t     rs_val;
      reg_addr_t rt;
      word_t     rt_val;
      word_t     imm;
      reg_addr_t dest;
   } id_ex_t;

   typedef struct packed {
      logic      mem_read;
      logic      mem_write;
      logic      mem_to_reg;
      logic      reg_write;
      reg_addr_t dest;
      word_t     alu_result;
      word_t     store_data;
   } ex_mem_t;

   typedef struct packed {
      logic      we;
      reg_addr_t addr;
      word_t     data;
   } rf_write_t;

   typedef struct packed {
      word_t addr;
      logic  wen;
      logic  ren;
      word_t wdata;
   } ext_req_t;

endpackage

`default_nettype wire

// File: hw/cpu_config.svh
// core sizes; memories are word addressed and both hold CPU_XLEN-bit words
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and instruction word width
`define CPU_XLEN 32

// general registers, r0 reads as zero
`define CPU_REG_COUNT 32

// instruction memory holds 512 words
`define CPU_IMEM_ADDR_W 9

// data memory holds 1024 words, addressed by the low bits of the ALU result
`define CPU_DMEM_ADDR_W 10

`endif
